/* Bender.yml */
package:
  name: execCore

sources:
  - execPkg.sv
  - execBusIf.sv
  - alu.sv
  - regFile.sv
  - dataMem.sv
  - pcUnit.sv
  - execControl.sv
  - execCore.sv
  - target: test
    files:
      - execCore_tb.sv

/* alu.sv */
module alu (
	input execPkg::aluOp op,
	input execPkg::word x,
	input execPkg::word y,
	output execPkg::word result
);

	logic [4:0] shamt;
	logic signedLess;
	logic unsignedLess;

	assign shamt = y[4:0]; // only the low five bits shift
	assign signedLess = $signed(x) < $signed(y);
	assign unsignedLess = x < y;

	always_comb
	begin
		case (op)
			execPkg::AluAdd:  result = x + y;
			execPkg::AluSub:  result = x - y;
			execPkg::AluSll:  result = x << shamt;
			execPkg::AluSrl:  result = x >> shamt;
			execPkg::AluSra:  result = execPkg::word'($signed(x) >>> shamt);
			execPkg::AluXor:  result = x ^ y;
			execPkg::AluOr:   result = x | y;
			execPkg::AluAnd:  result = x & y;
			// compares give 0 or 1
			execPkg::AluSlt:  result = {31'b0, signedLess};
			execPkg::AluSltu: result = {31'b0, unsignedLess};
			execPkg::AluEq:   result = {31'b0, x == y};
			execPkg::AluNe:   result = {31'b0, x != y};
			execPkg::AluGe:   result = {31'b0, !signedLess};
			execPkg::AluGeu:  result = {31'b0, !unsignedLess};
			default:          result = x + y;
		endcase
	end

endmodule

/* dataMem.sv */
module dataMem #(
	parameter int DataMemWords = 256
) (
	input logic clk,
	memPortIf.memory mem
);

	localparam int AddrBits = $clog2(DataMemWords);

	execPkg::word store [DataMemWords];
	logic [AddrBits-1:0] wordIndex;
	execPkg::word rawWord;
	execPkg::word shifted;

	assign wordIndex = mem.addr[AddrBits+1:2];
	assign rawWord = store[wordIndex];
	assign shifted = rawWord >> {mem.addr[1:0], 3'b000}; // bring addressed lane down

	always_ff @(posedge clk)
	begin
		if (mem.writeEnable)
		begin
			case (mem.func3[1:0])
				2'd0: store[wordIndex][{mem.addr[1:0], 3'b000} +: 8] <= mem.writeData[7:0];
				2'd1: store[wordIndex][{mem.addr[1], 4'b0000} +: 16] <= mem.writeData[15:0];
				default: store[wordIndex] <= mem.writeData;
			endcase
		end
	end

	// lb lh lw lbu lhu
	always_comb
	begin
		case (mem.func3)
			3'd0: mem.readData = {{24{shifted[7]}}, shifted[7:0]};
			3'd1: mem.readData = {{16{shifted[15]}}, shifted[15:0]};
			3'd4: mem.readData = {24'b0, shifted[7:0]};
			3'd5: mem.readData = {16'b0, shifted[15:0]};
			default: mem.readData = rawWord;
		endcase
	end

	// upper address bits are dropped by wordIndex, so catch overruns here
	addrInRange: assert property (
		@(posedge clk)
		(mem.readEnable || mem.writeEnable) |-> (mem.addr[31:2] < DataMemWords)
	);

endmodule

/* execBusIf.sv */
interface regPortIf;
	execPkg::regAddr rs1;
	execPkg::regAddr rs2;
	execPkg::word readData1; // combinational read
	execPkg::word readData2;
	logic writeEnable;
	execPkg::regAddr writeAddr;
	execPkg::word writeData; // lands at the rising edge

	modport control (
		output rs1, rs2, writeEnable, writeAddr, writeData,
		input readData1, readData2
	);

	modport rf (
		input rs1, rs2, writeEnable, writeAddr, writeData,
		output readData1, readData2
	);
endinterface

interface memPortIf;
	execPkg::word addr; // byte address
	execPkg::func3Field func3; // access width and signedness
	logic writeEnable;
	execPkg::word writeData;
	logic readEnable;
	execPkg::word readData; // already shifted and extended

	modport control (
		output addr, func3, writeEnable, writeData, readEnable,
		input readData
	);

	modport memory (
		input addr, func3, writeEnable, writeData, readEnable,
		output readData
	);
endinterface

/* execControl.sv */
module execControl (
	input logic clk,
	input logic reset,
	input execPkg::word instr,
	input logic instrValid,
	input execPkg::word pc,
	regPortIf.control regs,
	memPortIf.control mem,
	output execPkg::aluOp aluOp,
	output execPkg::word aluX,
	output execPkg::word aluY,
	input execPkg::word aluResult,
	output logic step,
	output logic takeTarget,
	output execPkg::word target,
	output logic regWriteEnable,
	output execPkg::regAddr regWriteAddr,
	output execPkg::word regWriteData
);

	execPkg::opcode op;
	execPkg::regAddr rdField;
	execPkg::func3Field func3;
	logic altFunc; // func7 bit 5, sub and sra
	execPkg::word immI, immS, immB, immU, immJ;
	execPkg::word imm, src1, src2, linkPc;
	execPkg::wbKind kind;
	logic isJump;

	// stage register
	execPkg::wbKind stageKind;
	execPkg::regAddr stageRd;
	execPkg::word stageResult;
	execPkg::word stageStoreData;
	execPkg::func3Field stageFunc3;

	function automatic execPkg::aluOp arithOp(input execPkg::func3Field f3, input logic alt);
		case (f3)
			3'd0: return alt ? execPkg::AluSub : execPkg::AluAdd;
			3'd1: return execPkg::AluSll;
			3'd2: return execPkg::AluSlt;
			3'd3: return execPkg::AluSltu;
			3'd4: return execPkg::AluXor;
			3'd5: return alt ? execPkg::AluSra : execPkg::AluSrl;
			3'd6: return execPkg::AluOr;
			default: return execPkg::AluAnd;
		endcase
	endfunction

	function automatic execPkg::aluOp branchOp(input execPkg::func3Field f3);
		case (f3)
			3'd1: return execPkg::AluNe;
			3'd4: return execPkg::AluSlt;
			3'd5: return execPkg::AluGe;
			3'd6: return execPkg::AluSltu;
			3'd7: return execPkg::AluGeu;
			default: return execPkg::AluEq;
		endcase
	endfunction

	assign op = execPkg::opcode'(instr[6:0]);
	assign rdField = instr[11:7];
	assign func3 = instr[14:12];
	assign altFunc = instr[30];
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign regs.rs1 = instr[19:15];
	assign regs.rs2 = instr[24:20];
	// newest value comes from the held instruction
	assign src1 = (regWriteEnable && regWriteAddr == regs.rs1) ? regWriteData : regs.readData1;
	assign src2 = (regWriteEnable && regWriteAddr == regs.rs2) ? regWriteData : regs.readData2;
	assign linkPc = pc + 32'd4;

	always_comb
	begin
		aluOp = execPkg::AluAdd;
		aluX = src1;
		aluY = immI;
		imm = immI;
		kind = execPkg::WbNone;
		isJump = 1'b0;
		case (op)
			execPkg::OpReg:
			begin
				aluOp = arithOp(func3, altFunc);
				aluY = src2;
				kind = execPkg::WbRegWrite;
			end
			execPkg::OpImm:
			begin
				aluOp = arithOp(func3, altFunc && func3 == 3'd5); // no subi
				kind = execPkg::WbRegWrite;
			end
			execPkg::OpLoad: kind = execPkg::WbMemReadRegWrite;
			execPkg::OpStore:
			begin
				aluY = immS;
				kind = execPkg::WbMemWrite;
			end
			execPkg::OpBranch:
			begin
				aluOp = branchOp(func3);
				aluY = src2;
				imm = immB;
			end
			execPkg::OpJal:
			begin
				imm = immJ;
				isJump = 1'b1;
				kind = execPkg::WbLinkWrite;
			end
			execPkg::OpJalr:
			begin
				isJump = 1'b1; // target from src1 + immI
				kind = execPkg::WbLinkWrite;
			end
			execPkg::OpLui:
			begin
				aluX = '0;
				aluY = immU;
				kind = execPkg::WbRegWrite;
			end
			execPkg::OpAuipc:
			begin
				aluX = pc;
				aluY = immU;
				kind = execPkg::WbRegWrite;
			end
			default: kind = execPkg::WbNone;
		endcase
		// rd 0 writes are dropped here, store bits 11:7 are imm
		if (!instrValid || (rdField == '0 && kind != execPkg::WbMemWrite))
			kind = execPkg::WbNone;
	end

	assign step = instrValid;
	assign takeTarget = isJump || (op == execPkg::OpBranch && aluResult[0]);
	assign target = (op == execPkg::OpJalr) ? {aluResult[31:1], 1'b0} : pc + imm;

	always_ff @(posedge clk)
	begin
		if (reset)
			stageKind <= execPkg::WbNone;
		else
			stageKind <= kind;
	end

	always_ff @(posedge clk)
	begin
		stageRd <= rdField;
		stageResult <= (kind == execPkg::WbLinkWrite) ? linkPc : aluResult;
		stageStoreData <= src2;
		stageFunc3 <= func3;
	end

	assign mem.addr = stageResult;
	assign mem.func3 = stageFunc3;
	assign mem.writeEnable = stageKind == execPkg::WbMemWrite;
	assign mem.writeData = stageStoreData;
	assign mem.readEnable = stageKind == execPkg::WbMemReadRegWrite;

	assign regWriteEnable = stageKind inside {execPkg::WbRegWrite, execPkg::WbMemReadRegWrite,
		execPkg::WbLinkWrite};
	assign regWriteAddr = stageRd;
	assign regWriteData = mem.readEnable ? mem.readData : stageResult;
	assign regs.writeEnable = regWriteEnable;
	assign regs.writeAddr = regWriteAddr;
	assign regs.writeData = regWriteData;

	noWriteToX0: assert property (
		@(posedge clk) disable iff (reset)
		!(regWriteEnable && regWriteAddr == '0)
	);

endmodule

/* execCore.sv */
module execCore #(
	parameter int DataMemWords = 256,
	parameter execPkg::word ResetPc = '0
) (
	input logic clk,
	input logic reset,
	input execPkg::word instr,
	input logic instrValid,
	output execPkg::word pc,
	output logic regWriteEnable,
	output execPkg::regAddr regWriteAddr,
	output execPkg::word regWriteData
);

	regPortIf regBus ();
	memPortIf memBus ();

	execPkg::aluOp aluOp;
	execPkg::word aluX;
	execPkg::word aluY;
	execPkg::word aluResult;
	logic step;
	logic takeTarget;
	execPkg::word target;

	execControl control0 (
		.clk, .reset, .instr, .instrValid, .pc,
		.regs(regBus.control), .mem(memBus.control),
		.aluOp, .aluX, .aluY, .aluResult,
		.step, .takeTarget, .target,
		.regWriteEnable, .regWriteAddr, .regWriteData
	);

	alu alu0 (.op(aluOp), .x(aluX), .y(aluY), .result(aluResult));

	regFile regFile0 (.clk, .reset, .regs(regBus.rf));

	dataMem #(.DataMemWords(DataMemWords)) dataMem0 (.clk, .mem(memBus.memory));

	pcUnit #(.ResetPc(ResetPc)) pcUnit0 (.clk, .reset, .step, .takeTarget, .target, .pc);

endmodule

/* execCore_tb.sv */
module execCore_tb;

	localparam int ClockPeriod = 100;
	localparam int ResetCycles = 10;
	localparam int DriveDelay = 10; // after the rising edge
	localparam int WatchdogMargin = 10; // cycles on top of the worst case
	localparam execPkg::word ResetPc = 32'h0;

	// instruction, pc after acceptance and the writeback seen next cycle
	typedef struct packed {
		execPkg::word instr;
		execPkg::word pc;
		logic we;
		execPkg::regAddr rd;
		execPkg::word data;
	} stepEntry;

	logic clk;
	logic reset;
	execPkg::word instr;
	logic instrValid;
	execPkg::word pc;
	logic regWriteEnable;
	execPkg::regAddr regWriteAddr;
	execPkg::word regWriteData;

	stepEntry entries[$];
	execPkg::word at; // pc of the next instruction while the table is built
	logic [31:0] lfsrState;
	logic tableReady;

	execCore #(.DataMemWords(256), .ResetPc(ResetPc)) dut0 (
		.clk, .reset, .instr, .instrValid, .pc,
		.regWriteEnable, .regWriteAddr, .regWriteData
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	function automatic execPkg::word encR(input logic [6:0] f7, input execPkg::regAddr rs2,
		input execPkg::regAddr rs1, input logic [2:0] f3, input execPkg::regAddr rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic execPkg::word encI(input logic [11:0] imm, input execPkg::regAddr rs1,
		input logic [2:0] f3, input execPkg::regAddr rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic execPkg::word encS(input logic [11:0] imm, input execPkg::regAddr rs2,
		input execPkg::regAddr rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic execPkg::word encB(input logic [12:0] imm, input execPkg::regAddr rs1,
		input execPkg::regAddr rs2, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic execPkg::word encU(input logic [19:0] imm, input execPkg::regAddr rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic execPkg::word encJ(input logic [20:0] imm, input execPkg::regAddr rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic addEntry(input execPkg::word w, input execPkg::word nextPc, input logic we,
		input execPkg::regAddr rd, input execPkg::word data);
		stepEntry e;
		e.instr = w;
		e.pc = nextPc;
		e.we = we;
		e.rd = rd;
		e.data = data;
		entries.push_back(e);
		at = nextPc;
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("[ERROR] time %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// galois lfsr stepped once per bit taken
	function automatic int drawBits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			value = (value << 1) | lfsrState[0];
			lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
		end
		return value;
	endfunction

	task automatic buildTable();
		execPkg::word link;
		// register and immediate ALU ops on x1 = 5 and x2 = -3
		addEntry(encI(12'd5, 5'd0, 3'd0, 5'd1, 7'b0010011), at + 4, 1'b1, 5'd1, 32'd5);
		addEntry(encI(12'hFFD, 5'd0, 3'd0, 5'd2, 7'b0010011), at + 4, 1'b1, 5'd2, 32'hFFFF_FFFD);
		addEntry(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), at + 4, 1'b1, 5'd3, 32'd2);
		addEntry(encR(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), at + 4, 1'b1, 5'd4, 32'd8);
		addEntry(encR(7'h00, 5'd1, 5'd1, 3'd1, 5'd5), at + 4, 1'b1, 5'd5, 32'h0000_00A0);
		addEntry(encR(7'h00, 5'd1, 5'd2, 3'd5, 5'd6), at + 4, 1'b1, 5'd6, 32'h07FF_FFFF);
		addEntry(encR(7'h20, 5'd1, 5'd2, 3'd5, 5'd7), at + 4, 1'b1, 5'd7, 32'hFFFF_FFFF);
		addEntry(encR(7'h00, 5'd1, 5'd2, 3'd2, 5'd8), at + 4, 1'b1, 5'd8, 32'd1);
		addEntry(encR(7'h00, 5'd1, 5'd2, 3'd3, 5'd9), at + 4, 1'b1, 5'd9, 32'd0);
		addEntry(encR(7'h00, 5'd2, 5'd1, 3'd4, 5'd10), at + 4, 1'b1, 5'd10, 32'hFFFF_FFF8);
		addEntry(encR(7'h00, 5'd2, 5'd1, 3'd6, 5'd11), at + 4, 1'b1, 5'd11, 32'hFFFF_FFFD);
		addEntry(encR(7'h00, 5'd2, 5'd1, 3'd7, 5'd12), at + 4, 1'b1, 5'd12, 32'd5);
		addEntry(encI(12'd3, 5'd1, 3'd1, 5'd13, 7'b0010011), at + 4, 1'b1, 5'd13, 32'h28);
		addEntry(encI(12'd28, 5'd2, 3'd5, 5'd14, 7'b0010011), at + 4, 1'b1, 5'd14, 32'hF);
		addEntry(encI(12'h401, 5'd2, 3'd5, 5'd15, 7'b0010011), at + 4, 1'b1, 5'd15, 32'hFFFF_FFFE);
		addEntry(encI(12'hFFF, 5'd1, 3'd2, 5'd16, 7'b0010011), at + 4, 1'b1, 5'd16, 32'd0);
		addEntry(encI(12'hFFF, 5'd1, 3'd3, 5'd17, 7'b0010011), at + 4, 1'b1, 5'd17, 32'd1);
		addEntry(encI(12'h0FF, 5'd1, 3'd4, 5'd18, 7'b0010011), at + 4, 1'b1, 5'd18, 32'hFA);
		addEntry(encI(12'h070, 5'd1, 3'd6, 5'd19, 7'b0010011), at + 4, 1'b1, 5'd19, 32'h75);
		addEntry(encI(12'h0F0, 5'd2, 3'd7, 5'd20, 7'b0010011), at + 4, 1'b1, 5'd20, 32'hF0);
		addEntry(encI(12'd7, 5'd1, 3'd0, 5'd0, 7'b0010011), at + 4, 1'b0, 5'd0, 32'd0); // rd x0
		// dependent chain on x21 and x22
		addEntry(encI(12'd100, 5'd0, 3'd0, 5'd21, 7'b0010011), at + 4, 1'b1, 5'd21, 32'd100);
		addEntry(encI(12'd1, 5'd21, 3'd0, 5'd21, 7'b0010011), at + 4, 1'b1, 5'd21, 32'd101);
		addEntry(encR(7'h00, 5'd21, 5'd21, 3'd0, 5'd22), at + 4, 1'b1, 5'd22, 32'd202);
		addEntry(encR(7'h20, 5'd21, 5'd22, 3'd0, 5'd21), at + 4, 1'b1, 5'd21, 32'd101);
		// lui and auipc
		addEntry(encU(20'h12345, 5'd23, 7'b0110111), at + 4, 1'b1, 5'd23, 32'h1234_5000);
		addEntry(encU(20'h00001, 5'd24, 7'b0010111), at + 4, 1'b1, 5'd24, at + 32'h1000);
		// stores into the word at 0x100 then loads of every width
		addEntry(encI(12'h100, 5'd0, 3'd0, 5'd25, 7'b0010011), at + 4, 1'b1, 5'd25, 32'h100);
		addEntry(encU(20'h89ABD, 5'd26, 7'b0110111), at + 4, 1'b1, 5'd26, 32'h89AB_D000);
		addEntry(encI(12'hDEF, 5'd26, 3'd0, 5'd26, 7'b0010011), at + 4, 1'b1, 5'd26, 32'h89AB_CDEF);
		addEntry(encS(12'd0, 5'd26, 5'd25, 3'd2), at + 4, 1'b0, 5'd0, 32'd0);
		addEntry(encS(12'd1, 5'd1, 5'd25, 3'd0), at + 4, 1'b0, 5'd0, 32'd0);
		addEntry(encS(12'd2, 5'd2, 5'd25, 3'd1), at + 4, 1'b0, 5'd0, 32'd0); // now FFFD05EF
		addEntry(encI(12'd0, 5'd25, 3'd2, 5'd27, 7'b0000011), at + 4, 1'b1, 5'd27, 32'hFFFD_05EF);
		addEntry(encI(12'd0, 5'd25, 3'd0, 5'd28, 7'b0000011), at + 4, 1'b1, 5'd28, 32'hFFFF_FFEF);
		addEntry(encI(12'd0, 5'd25, 3'd4, 5'd29, 7'b0000011), at + 4, 1'b1, 5'd29, 32'hEF);
		addEntry(encI(12'd1, 5'd25, 3'd0, 5'd30, 7'b0000011), at + 4, 1'b1, 5'd30, 32'd5);
		addEntry(encI(12'd2, 5'd25, 3'd1, 5'd31, 7'b0000011), at + 4, 1'b1, 5'd31, 32'hFFFF_FFFD);
		addEntry(encI(12'd2, 5'd25, 3'd5, 5'd27, 7'b0000011), at + 4, 1'b1, 5'd27, 32'hFFFD);
		addEntry(encI(12'd0, 5'd25, 3'd5, 5'd28, 7'b0000011), at + 4, 1'b1, 5'd28, 32'h05EF);
		addEntry(encI(12'd3, 5'd25, 3'd4, 5'd29, 7'b0000011), at + 4, 1'b1, 5'd29, 32'hFF);
		addEntry(encI(12'd0, 5'd25, 3'd2, 5'd30, 7'b0000011), at + 4, 1'b1, 5'd30, 32'hFFFD_05EF);
		addEntry(encI(12'd1, 5'd30, 3'd0, 5'd31, 7'b0010011), at + 4, 1'b1, 5'd31, 32'hFFFD_05F0);
		// each branch taken then not taken
		addEntry(encB(13'd16, 5'd1, 5'd1, 3'd0), at + 16, 1'b0, 5'd0, 32'd0);
		addEntry(encB(13'd16, 5'd1, 5'd2, 3'd0), at + 4, 1'b0, 5'd0, 32'd0);
		addEntry(encB(13'd16, 5'd1, 5'd2, 3'd1), at + 16, 1'b0, 5'd0, 32'd0);
		addEntry(encB(13'd16, 5'd1, 5'd1, 3'd1), at + 4, 1'b0, 5'd0, 32'd0);
		addEntry(encB(13'd16, 5'd2, 5'd1, 3'd4), at + 16, 1'b0, 5'd0, 32'd0);
		addEntry(encB(13'd16, 5'd1, 5'd2, 3'd4), at + 4, 1'b0, 5'd0, 32'd0);
		addEntry(encB(13'd16, 5'd1, 5'd2, 3'd5), at + 16, 1'b0, 5'd0, 32'd0);
		addEntry(encB(13'd16, 5'd2, 5'd1, 3'd5), at + 4, 1'b0, 5'd0, 32'd0);
		addEntry(encB(13'd16, 5'd1, 5'd2, 3'd6), at + 16, 1'b0, 5'd0, 32'd0);
		addEntry(encB(13'd16, 5'd2, 5'd1, 3'd6), at + 4, 1'b0, 5'd0, 32'd0);
		addEntry(encB(13'd16, 5'd2, 5'd1, 3'd7), at + 16, 1'b0, 5'd0, 32'd0);
		addEntry(encB(13'd16, 5'd1, 5'd2, 3'd7), at + 4, 1'b0, 5'd0, 32'd0);
		// jumps
		addEntry(encJ(21'h40, 5'd1), at + 32'h40, 1'b1, 5'd1, at + 4);
		link = at + 4;
		addEntry(encI(12'h021, 5'd25, 3'd0, 5'd5, 7'b1100111), 32'h120, 1'b1, 5'd5, link);
		addEntry(encI(12'd0, 5'd5, 3'd0, 5'd6, 7'b0010011), at + 4, 1'b1, 5'd6, link);
		addEntry(encJ(21'h1FFFF0, 5'd0), at - 16, 1'b0, 5'd0, 32'd0); // back 16 without a link
	endtask

	initial
	begin
		stepEntry e;
		int gap;
		reset = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		tableReady = 1'b0;
		lfsrState = 32'hb894_5a2e;
		at = ResetPc;
		buildTable();
		tableReady = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		#DriveDelay reset = 1'b0;
		checkValue("pc", pc, ResetPc);
		checkValue("regWriteEnable", regWriteEnable, 1'b0);
		foreach (entries[i])
		begin
			e = entries[i];
			instr = e.instr;
			instrValid = 1'b1;
			@(posedge clk);
			#DriveDelay;
			checkValue("pc", pc, e.pc);
			checkValue("regWriteEnable", regWriteEnable, e.we);
			if (e.we)
			begin
				checkValue("regWriteAddr", regWriteAddr, e.rd);
				checkValue("regWriteData", regWriteData, e.data);
			end
			instrValid = 1'b0;
			gap = drawBits(2); // zero to three idle cycles
			repeat (gap)
			begin
				@(posedge clk);
				#DriveDelay;
				checkValue("regWriteEnable", regWriteEnable, 1'b0);
				checkValue("pc", pc, e.pc); // holds while idle
			end
		end
		$display("all tests passed");
		$finish;
	end

	// worst case is one accept plus three idle cycles per entry
	initial
	begin
		wait (tableReady);
		#((entries.size() * 4 + ResetCycles + WatchdogMargin) * ClockPeriod);
		$display("the run did not finish within the expected time");
		$display("tests failed");
		$fatal(1, "watchdog timeout");
	end

endmodule

/* execPkg.sv */
package execPkg;

	typedef logic [31:0] word; // data or address value
	typedef logic [4:0] regAddr;
	typedef logic [2:0] func3Field; // alu variant, branch condition, access width

	// major opcodes kept by this core
	typedef enum logic [6:0] {
		OpLoad   = 7'b0000011,
		OpImm    = 7'b0010011,
		OpAuipc  = 7'b0010111,
		OpStore  = 7'b0100011,
		OpReg    = 7'b0110011,
		OpLui    = 7'b0110111,
		OpBranch = 7'b1100011,
		OpJalr   = 7'b1100111,
		OpJal    = 7'b1101111
	} opcode;

	typedef enum logic [3:0] {
		AluAdd,
		AluSub,
		AluSll,
		AluSrl,
		AluSra,
		AluXor,
		AluOr,
		AluAnd,
		AluSlt,
		AluSltu,
		AluEq,
		AluNe,
		AluGe,
		AluGeu
	} aluOp;

	// what the held instruction does in its second cycle
	typedef enum logic [2:0] {
		WbNone,
		WbRegWrite,
		WbMemReadRegWrite,
		WbMemWrite,
		WbLinkWrite
	} wbKind;

endpackage

/* pcUnit.sv */
module pcUnit #(
	parameter execPkg::word ResetPc = '0
) (
	input logic clk,
	input logic reset,
	input logic step,
	input logic takeTarget,
	input execPkg::word target,
	output execPkg::word pc
);

	execPkg::word nextPc;

	// taken branch or any jump goes to target
	assign nextPc = takeTarget ? target : pc + 32'd4;

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= ResetPc;
		else if (step) // holds while no instruction is offered
			pc <= nextPc;
	end

endmodule

/* project.f */
execPkg.sv
execBusIf.sv
alu.sv
regFile.sv
dataMem.sv
pcUnit.sv
execControl.sv
execCore.sv
execCore_tb.sv

/* regFile.sv */
module regFile (
	input logic clk,
	input logic reset,
	regPortIf.rf regs
);

	execPkg::word file [1:31]; // x0 has no storage

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 1; i < 32; i++)
				file[i] <= '0;
		end
		else if (regs.writeEnable && regs.writeAddr != '0)
			file[regs.writeAddr] <= regs.writeData;
	end

	assign regs.readData1 = (regs.rs1 == '0) ? '0 : file[regs.rs1];
	assign regs.readData2 = (regs.rs2 == '0) ? '0 : file[regs.rs2];

endmodule
